//--- stm.f
design/stm_geom_pkg.sv
design/stm_bus_pkg.sv
design/stm_chunk_ram.sv
design/stm_arbiter.sv
design/stm_table.sv
design/stm_line_align.sv
design/stm_apb_port.sv
design/stm_top.sv
verification/stm_tb.sv

//--- Bender.yml
package:
  name: stm

sources:
  - files:
      - design/stm_geom_pkg.sv
      - design/stm_bus_pkg.sv
      - design/stm_chunk_ram.sv
      - design/stm_arbiter.sv
      - design/stm_table.sv
      - design/stm_line_align.sv
      - design/stm_apb_port.sv
      - design/stm_top.sv
  - target: simulation
    files:
      - verification/stm_tb.sv

//--- verification/stm_tb.sv
// Shared lookup table testbench
`default_nettype none

module stm_tb
    import stm_geom_pkg::*;
    import stm_bus_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int N_RDBACK   = 32;
    localparam int N_LOOKUP   = 16;              // Per directed lookup test
    localparam int N_DUAL     = 100;             // Cycles with both clients streaming
    localparam int N_PRIO     = 4;
    localparam int PLANNED    = ENTRIES + N_RDBACK + 2 * N_LOOKUP + 2 * N_DUAL + 3 * N_PRIO;

    logic        cclk;
    logic        q_reset;
    lookup_req_t lk [2];
    logic        rdy [2];
    lookup_rsp_t rsp [2];
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;
    entry_t      model [ENTRIES];                // Shadow of the table
    tbl_addr_t   pend0 [$];                      // Directed lookups for client 0
    tbl_addr_t   pend1 [$];
    logic        stream_on;
    logic        fair_on;
    int          seed;
    int          value_errors;
    int          other_errors;
    string       test_name;
    logic        acc_d1 [2];
    logic        acc_d2 [2];
    logic        starve_d1 [2];
    line_t       exp_d1 [2];
    line_t       exp_d2 [2];

    stm_top i_dut (
        .cclk            (cclk),
        .q_reset         (q_reset),
        .i_lookup0       (lk[0]),
        .i_lookup1       (lk[1]),
        .o_lookup_ready0 (rdy[0]),
        .o_lookup_ready1 (rdy[1]),
        .o_lookup_rsp0   (rsp[0]),
        .o_lookup_rsp1   (rsp[1]),
        .i_apb           (apb),
        .o_apb           (apb_rsp)
    );

    always #(CLK_PERIOD / 2) cclk = ~cclk;

    function automatic line_t model_line(input tbl_addr_t a);
        line_t l;
        for (int k = 0; k < CHUNKS; k++) begin
            l[k] = model[tbl_addr_t'(a + k)];    // Wraps at the table end
        end
        return l;
    endfunction

    // Expected line and acceptance travel two edges to meet the response
    always @(posedge cclk) begin
        for (int c = 0; c < 2; c++) begin
            acc_d1[c]    <= q_reset ? 1'b0 : lk[c].valid & rdy[c];
            acc_d2[c]    <= q_reset ? 1'b0 : acc_d1[c];
            starve_d1[c] <= q_reset ? 1'b0 : lk[c].valid & ~rdy[c];
            exp_d1[c]    <= model_line(lk[c].addr);
            exp_d2[c]    <= exp_d1[c];
        end
    end

    for (genvar c = 0; c < 2; c++) begin : g_check
        a_on_time: assert property (@(posedge cclk) disable iff (q_reset)
            acc_d2[c] |-> rsp[c].valid)
            else begin
                other_errors++;
                $display("[%s] lookup%0d gave no response two edges after acceptance",
                         test_name, c);
            end
        a_no_extra: assert property (@(posedge cclk) disable iff (q_reset)
            rsp[c].valid |-> acc_d2[c])
            else begin
                other_errors++;
                $display("[%s] lookup%0d gave a response nobody asked for", test_name, c);
            end
        a_line: assert property (@(posedge cclk) disable iff (q_reset)
            acc_d2[c] && rsp[c].valid |-> rsp[c].line == exp_d2[c])
            else begin
                value_errors++;
                $display("** Error [%s] lookup%0d line: expected %h, actual %h", test_name, c,
                         $sampled(exp_d2[c]), $sampled(rsp[c].line));
            end
        a_fair: assert property (@(posedge cclk) disable iff (q_reset)
            fair_on && starve_d1[c] |-> !(lk[c].valid && !rdy[c]))
            else begin
                other_errors++;
                $display("[%s] lookup%0d held off two cycles in a row", test_name, c);
            end
    end

    // First access cycle of a write is the grant cycle
    a_apb_first: assert property (@(posedge cclk) disable iff (q_reset)
        apb.psel && apb.penable && apb.pwrite && !apb_rsp.pready |-> !rdy[0] && !rdy[1])
        else begin
            other_errors++;
            $display("[%s] a lookup client was ready during an APB write grant", test_name);
        end

    task automatic next_lookup(input int c);
        lk[c].valid = 1'b1;
        if (c == 0 && pend0.size() > 0) begin
            lk[c].addr = pend0.pop_front();
        end else if (c == 1 && pend1.size() > 0) begin
            lk[c].addr = pend1.pop_front();
        end else if (stream_on) begin
            lk[c].addr = tbl_addr_t'($random(seed));
        end else begin
            lk[c].valid = 1'b0;
        end
    endtask

    // Clients hold a request until the edge that accepts it
    initial begin : lookup_driver
        lk[0] = '0;
        lk[1] = '0;
        forever begin
            @(negedge cclk);
            for (int c = 0; c < 2; c++) begin
                if (q_reset) begin
                    lk[c].valid = 1'b0;
                end else if (!lk[c].valid || acc_d1[c]) begin
                    next_lookup(c);
                end
            end
        end
    end

    task automatic apb_transfer(input logic wr, input tbl_addr_t a, input entry_t d);
        apb.psel    = 1'b1;                      // Setup phase
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = {a, 2'b00};
        apb.pwdata  = d;
        @(negedge cclk);
        apb.penable = 1'b1;
        @(negedge cclk);
        while (!apb_rsp.pready) begin
            @(negedge cclk);
        end
        if (wr) begin
            model[a] = d;
        end else begin
            assert (apb_rsp.prdata == model[a])
                else begin
                    value_errors++;
                    $display("** Error [%s] prdata at entry %0d: expected %h, actual %h",
                             test_name, a, model[a], apb_rsp.prdata);
                end
        end
        @(negedge cclk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic drain_lookups();
        while (pend0.size() > 0 || pend1.size() > 0 || lk[0].valid || lk[1].valid) begin
            @(negedge cclk);
        end
        repeat (3) @(negedge cclk);              // Last responses land
    endtask

    initial begin : watchdog
        repeat (PLANNED * 40) @(posedge cclk);
        $display("Timeout: run did not finish within %0d cycles", PLANNED * 40);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        tbl_addr_t a;
        cclk         = 1'b0;
        q_reset      = 1'b1;
        apb          = '0;
        stream_on    = 1'b0;
        fair_on      = 1'b0;
        seed         = 47450;
        value_errors = 0;
        other_errors = 0;
        test_name    = "reset";
        repeat (2) @(negedge cclk);
        q_reset = 1'b0;
        @(negedge cclk);
        assert (!rsp[0].valid && !rsp[1].valid && !rdy[0] && !rdy[1] && !apb_rsp.pready)
            else begin
                other_errors++;
                $display("[reset] a valid, ready or pready output is high after reset");
            end

        test_name = "apb write and read-back";
        for (int i = 0; i < ENTRIES; i++) begin
            apb_transfer(1'b1, tbl_addr_t'(i), entry_t'($random(seed)));
        end
        apb_transfer(1'b0, 8'd0, '0);
        apb_transfer(1'b0, 8'd255, '0);
        for (int i = 0; i < N_RDBACK; i++) begin
            apb_transfer(1'b0, tbl_addr_t'($random(seed)), '0);
        end

        test_name = "aligned lookup";
        for (int i = 0; i < N_LOOKUP; i++) begin
            a = tbl_addr_t'($random(seed)) & 8'hfc;
            if (i % 2 == 0) begin
                pend0.push_back(a);
            end else begin
                pend1.push_back(a);
            end
        end
        drain_lookups();

        test_name = "unaligned and wrapping lookup";
        pend0.push_back(8'd254);
        pend1.push_back(8'd255);
        for (int i = 2; i < N_LOOKUP; i++) begin
            a      = tbl_addr_t'($random(seed));
            a[1:0] = 2'(1 + i % 3);              // Never a multiple of 4
            pend0.push_back(a);
        end
        drain_lookups();

        test_name = "two clients at once";
        stream_on = 1'b1;
        fair_on   = 1'b1;
        repeat (N_DUAL) @(negedge cclk);
        fair_on   = 1'b0;
        stream_on = 1'b0;
        drain_lookups();

        test_name = "apb priority";
        stream_on = 1'b1;
        repeat (3) @(negedge cclk);
        for (int i = 0; i < N_PRIO; i++) begin
            a = tbl_addr_t'($random(seed));
            apb_transfer(1'b1, a, entry_t'($random(seed)));
            pend0.push_back(a);                  // Must see the new entry
            pend1.push_back(tbl_addr_t'(a - 2));
            repeat (4) @(negedge cclk);
        end
        stream_on = 1'b0;
        drain_lookups();

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/stm_top.sv
// Shared lookup table top
`default_nettype none

module stm_top
    import stm_geom_pkg::*;
    import stm_bus_pkg::*;
(
    input  wire logic        cclk,
    input  wire logic        q_reset,
    input  wire lookup_req_t i_lookup0,
    input  wire lookup_req_t i_lookup1,
    output logic             o_lookup_ready0,
    output logic             o_lookup_ready1,
    output lookup_rsp_t      o_lookup_rsp0,
    output lookup_rsp_t      o_lookup_rsp1,
    input  wire apb_req_t    i_apb,
    output apb_rsp_t         o_apb
);

    tbl_op_t apb_op;                             // APB port request to the arbiter
    logic    apb_grant;
    tbl_op_t tbl_op;                             // Winner of this cycle
    tbl_rd_t tbl_rd;
    entry_t  apb_rdata;
    logic    apb_rdone;

    stm_arbiter i_arbiter (
        .cclk            (cclk),
        .q_reset         (q_reset),
        .i_lookup0       (i_lookup0),
        .i_lookup1       (i_lookup1),
        .o_lookup_ready0 (o_lookup_ready0),
        .o_lookup_ready1 (o_lookup_ready1),
        .i_apb_op        (apb_op),
        .o_apb_grant     (apb_grant),
        .o_op            (tbl_op)
    );

    stm_table i_table (
        .cclk    (cclk),
        .q_reset (q_reset),
        .i_op    (tbl_op),
        .o_rd    (tbl_rd)
    );

    stm_line_align i_line_align (
        .cclk          (cclk),
        .q_reset       (q_reset),
        .i_rd          (tbl_rd),
        .o_lookup_rsp0 (o_lookup_rsp0),
        .o_lookup_rsp1 (o_lookup_rsp1),
        .o_apb_rdata   (apb_rdata),
        .o_apb_rdone   (apb_rdone)
    );

    stm_apb_port i_apb_port (
        .cclk    (cclk),
        .q_reset (q_reset),
        .i_apb   (i_apb),
        .o_apb   (o_apb),
        .o_op    (apb_op),
        .i_grant (apb_grant),
        .i_rdata (apb_rdata),
        .i_rdone (apb_rdone)
    );

endmodule

`default_nettype wire

//--- design/stm_apb_port.sv
// APB configuration port
`default_nettype none

module stm_apb_port
    import stm_geom_pkg::*;
    import stm_bus_pkg::*;
(
    input  wire logic     cclk,
    input  wire logic     q_reset,
    input  wire apb_req_t i_apb,
    output apb_rsp_t      o_apb,
    output tbl_op_t       o_op,
    input  wire logic     i_grant,
    input  wire entry_t   i_rdata,
    input  wire logic     i_rdone
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,                                  // Operation offered to the arbiter
        ST_WAIT_RD,                              // Read granted, data on its way
        ST_DONE                                  // pready high for one cycle
    } apb_state_e;

    apb_state_e q_state;
    apb_state_e nxt_state;
    entry_t     q_prdata;

    always_comb begin
        nxt_state = q_state;
        case (q_state)
            ST_IDLE: begin
                if (i_apb.psel & ~i_apb.penable) begin
                    nxt_state = ST_REQ;
                end
            end
            ST_REQ: begin
                if (i_grant) begin
                    nxt_state = i_apb.pwrite ? ST_DONE : ST_WAIT_RD;
                end
            end
            ST_WAIT_RD: begin
                if (i_rdone) begin
                    nxt_state = ST_DONE;
                end
            end
            default: nxt_state = ST_IDLE;        // Access phase ends with pready
        endcase
    end

    always_ff @(posedge cclk) begin
        if (q_reset) begin
            q_state <= ST_IDLE;
        end else begin
            q_state <= nxt_state;
        end
    end

    always_ff @(posedge cclk) begin
        if (i_rdone && q_state == ST_WAIT_RD) begin
            q_prdata <= i_rdata;
        end
    end

    // Master holds paddr and pwdata stable until pready
    always_comb begin
        o_op.rd    = (q_state == ST_REQ) & ~i_apb.pwrite;
        o_op.wr    = (q_state == ST_REQ) & i_apb.pwrite;
        o_op.addr  = i_apb.paddr[APB_ADDR_W-1:2];      // Word address of the entry
        o_op.wdata = i_apb.pwdata;
        o_op.src   = SRC_APB;
    end

    assign o_apb.pready = (q_state == ST_DONE);
    assign o_apb.prdata = q_prdata;

endmodule

`default_nettype wire

//--- design/stm_line_align.sv
// Line rotation and return routing
`default_nettype none

module stm_line_align
    import stm_geom_pkg::*;
    import stm_bus_pkg::*;
(
    input  wire logic    cclk,
    input  wire logic    q_reset,
    input  wire tbl_rd_t i_rd,
    output lookup_rsp_t  o_lookup_rsp0,
    output lookup_rsp_t  o_lookup_rsp1,
    output entry_t       o_apb_rdata,
    output logic         o_apb_rdone
);

    line_t rot_line;                             // Addressed entry first
    logic  hit0;
    logic  hit1;
    logic  hit_apb;

    // Line entry k sits in chunk start + k, wrapping over the four chunks
    always_comb begin
        for (int k = 0; k < CHUNKS; k++) begin
            rot_line[k] = i_rd.data[chunk_sel_t'(i_rd.start + chunk_sel_t'(k))];
        end
    end

    assign hit0    = i_rd.valid & (i_rd.src == SRC_CLIENT0);
    assign hit1    = i_rd.valid & (i_rd.src == SRC_CLIENT1);
    assign hit_apb = i_rd.valid & (i_rd.src == SRC_APB);

    always_ff @(posedge cclk) begin
        if (q_reset) begin
            o_lookup_rsp0.valid <= 1'b0;
            o_lookup_rsp1.valid <= 1'b0;
            o_apb_rdone         <= 1'b0;
        end else begin
            o_lookup_rsp0.valid <= hit0;         // One cycle pulse per read
            o_lookup_rsp1.valid <= hit1;
            o_apb_rdone         <= hit_apb;
        end
    end

    always_ff @(posedge cclk) begin
        if (hit0) begin
            o_lookup_rsp0.line <= rot_line;
        end
        if (hit1) begin
            o_lookup_rsp1.line <= rot_line;
        end
        if (hit_apb) begin
            o_apb_rdata <= rot_line[0];          // APB wants the single entry
        end
    end

endmodule

`default_nettype wire

//--- design/stm_table.sv
// Chunked table storage
`default_nettype none

module stm_table
    import stm_geom_pkg::*;
    import stm_bus_pkg::*;
(
    input  wire logic    cclk,
    input  wire logic    q_reset,
    input  wire tbl_op_t i_op,
    output tbl_rd_t      o_rd
);

    row_t                    base_row;           // Row of the addressed entry
    chunk_sel_t              start_chunk;
    row_t       [CHUNKS-1:0] chunk_row;
    logic       [CHUNKS-1:0] chunk_wr;
    line_t                   chunk_rdata;
    logic                    q_valid;
    chunk_sel_t              q_start;
    src_t                    q_src;

    assign base_row    = i_op.addr[ADDR_W-1:SEL_W];
    assign start_chunk = i_op.addr[SEL_W-1:0];

    // Chunks below the start hold the tail of the line, one row further on
    always_comb begin
        for (int c = 0; c < CHUNKS; c++) begin
            chunk_row[c] = (chunk_sel_t'(c) >= start_chunk) ? base_row : base_row + 1'b1;
            chunk_wr[c]  = i_op.wr & (chunk_sel_t'(c) == start_chunk);
        end
    end

    for (genvar c = 0; c < CHUNKS; c++) begin : g_chunk
        stm_chunk_ram i_ram (
            .cclk    (cclk),
            .i_rd    (i_op.rd),
            .i_wr    (chunk_wr[c]),
            .i_row   (chunk_row[c]),
            .i_wdata (i_op.wdata),
            .o_rdata (chunk_rdata[c])
        );
    end

    always_ff @(posedge cclk) begin
        if (q_reset) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= i_op.rd;
        end
    end

    always_ff @(posedge cclk) begin
        q_start <= start_chunk;                  // Tag follows the RAM read
        q_src   <= i_op.src;
    end

    assign o_rd = '{valid: q_valid, data: chunk_rdata, start: q_start, src: q_src};

endmodule

`default_nettype wire

//--- design/stm_arbiter.sv
// Table operation arbiter
`default_nettype none

module stm_arbiter
    import stm_bus_pkg::*;
(
    input  wire logic        cclk,
    input  wire logic        q_reset,
    input  wire lookup_req_t i_lookup0,
    input  wire lookup_req_t i_lookup1,
    output logic             o_lookup_ready0,
    output logic             o_lookup_ready1,
    input  wire tbl_op_t     i_apb_op,
    output logic             o_apb_grant,
    output tbl_op_t          o_op
);

    logic apb_req;                               // APB port holds an operation
    logic want0;
    logic want1;
    logic gnt0;
    logic gnt1;
    logic q_rr_ptr;                              // Low favors client 0

    always_comb begin
        apb_req = i_apb_op.rd | i_apb_op.wr;
        want0   = i_lookup0.valid & ~apb_req;    // Clients only compete without APB
        want1   = i_lookup1.valid & ~apb_req;
        gnt0    = want0 & (~want1 | ~q_rr_ptr);
        gnt1    = want1 & (~want0 | q_rr_ptr);
    end

    // Pointer moves on only when both clients were asking
    always_ff @(posedge cclk) begin
        if (q_reset) begin
            q_rr_ptr <= 1'b0;
        end else if (want0 & want1) begin
            q_rr_ptr <= ~q_rr_ptr;
        end
    end

    always_comb begin
        o_op = '0;
        if (apb_req) begin
            o_op     = i_apb_op;
            o_op.src = SRC_APB;
        end else if (gnt0) begin
            o_op.rd   = 1'b1;
            o_op.addr = i_lookup0.addr;
            o_op.src  = SRC_CLIENT0;
        end else if (gnt1) begin
            o_op.rd   = 1'b1;
            o_op.addr = i_lookup1.addr;
            o_op.src  = SRC_CLIENT1;
        end
    end

    assign o_apb_grant     = apb_req;        // APB always wins its cycle
    assign o_lookup_ready0 = gnt0;
    assign o_lookup_ready1 = gnt1;

endmodule

`default_nettype wire

//--- design/stm_chunk_ram.sv
// Chunk memory
`default_nettype none

module stm_chunk_ram
    import stm_geom_pkg::*;
(
    input  wire logic   cclk,
    input  wire logic   i_rd,
    input  wire logic   i_wr,
    input  wire row_t   i_row,
    input  wire entry_t i_wdata,
    output entry_t      o_rdata
);

    entry_t mem [ROWS];                          // One entry per row

    always_ff @(posedge cclk) begin
        if (i_wr) begin
            mem[i_row] <= i_wdata;
        end
    end

    // Read data shows up the cycle after i_rd
    always_ff @(posedge cclk) begin
        if (i_rd) begin
            o_rdata <= mem[i_row];
        end
    end

endmodule

`default_nettype wire

//--- design/stm_bus_pkg.sv
// Lookup, APB and table operation buses
`default_nettype none

package stm_bus_pkg;

    import stm_geom_pkg::*;

    localparam int APB_ADDR_W = 10;             // Byte address, entry in bits 9:2

    typedef enum logic [1:0] {
        SRC_CLIENT0 = 2'd0,
        SRC_CLIENT1 = 2'd1,
        SRC_APB     = 2'd2
    } src_t;

    typedef struct packed {
        logic      valid;
        tbl_addr_t addr;                         // First entry of the line
    } lookup_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
    } lookup_rsp_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        entry_t                pwdata;
    } apb_req_t;

    typedef struct packed {
        logic   pready;
        entry_t prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic      rd;                           // Line read
        logic      wr;                           // Single entry write
        tbl_addr_t addr;
        entry_t    wdata;
        src_t      src;
    } tbl_op_t;

    typedef struct packed {
        logic       valid;
        line_t      data;                        // Raw words, indexed by chunk
        chunk_sel_t start;                       // Chunk holding the addressed entry
        src_t       src;
    } tbl_rd_t;

endpackage

`default_nettype wire

//--- design/stm_geom_pkg.sv
// Shared table geometry
`default_nettype none

package stm_geom_pkg;

    localparam int CHUNKS  = 4;                  // Chunk memories side by side
    localparam int ROWS    = 64;                 // Rows in each chunk
    localparam int ENTRY_W = 32;                 // Bits per entry
    localparam int ENTRIES = CHUNKS * ROWS;      // Whole table, 256 entries

    localparam int ADDR_W  = $clog2(ENTRIES);
    localparam int ROW_W   = $clog2(ROWS);
    localparam int SEL_W   = $clog2(CHUNKS);

    typedef logic [ENTRY_W-1:0] entry_t;         // One table entry
    typedef logic [ADDR_W-1:0]  tbl_addr_t;      // Entry address, chunk in low bits
    typedef logic [ROW_W-1:0]   row_t;           // Row inside one chunk
    typedef logic [SEL_W-1:0]   chunk_sel_t;     // Chunk index

    // Four consecutive entries, element 0 is the addressed one
    typedef entry_t [CHUNKS-1:0] line_t;

endpackage

`default_nettype wire
